// ==== include/display_defines.svh ====
`ifndef DISPLAY_DEFINES_SVH
`define DISPLAY_DEFINES_SVH

// signed input, two's complement
`define VALUE_WIDTH 15

// magnitude bits fed through the shift-and-add-3 loop
`define MAG_WIDTH 14

// four BCD nibbles
`define BCD_WIDTH 16

// largest magnitude that fits on four digits
`define MAX_MAGNITUDE 9999

`define DIGIT_BLANK 4'hA  // decoder shows all segments off
`define DIGIT_DASH  4'hF  // decoder shows middle bar only

`endif

// ==== hdl/display_pkg.sv ====
`include "display_defines.svh"

package display_pkg;

	// signed number as presented at the top level
	typedef logic signed [`VALUE_WIDTH-1:0] value_t;

	// unsigned magnitude shifted by the converter
	typedef logic [`MAG_WIDTH-1:0] magnitude_t;

	// one digit code: 0..9 decimal, dash, everything else blank
	typedef logic [3:0] digit_t;

	// active low, segment a in the msb down to g in the lsb
	typedef logic [6:0] segments_t;

	// converter sequencing
	typedef enum logic [1:0] {
		IDLE,    // waiting for start
		SHIFT,   // one magnitude bit per clock
		FINISH   // result settled, done pulse follows
	} conv_state_t;

endpackage

// ==== hdl/bin_to_bcd_converter.sv ====
`timescale 1ns/1ps
`include "display_defines.svh"

module bin_to_bcd_converter
	import display_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   start,
	input  value_t value,
	output logic   busy,
	output logic   conv_done,
	output logic   conv_negative,
	output logic   conv_overflow,
	output digit_t raw_thousands,
	output digit_t raw_hundreds,
	output digit_t raw_tens,
	output digit_t raw_units
);

	conv_state_t state;

	magnitude_t                    shift_reg;    // bits not yet moved into bcd
	logic [`BCD_WIDTH-1:0]         bcd;          // digits under construction
	logic [`BCD_WIDTH-1:0]         bcd_adjusted; // bcd after the add-3 step
	logic [$clog2(`MAG_WIDTH)-1:0] bit_count;    // shifts done so far
	logic [`VALUE_WIDTH-1:0]       abs_value;    // one bit wider than the magnitude

	// the most negative value only fits in the extra top bit
	always_comb begin
		if (value[`VALUE_WIDTH-1]) begin
			abs_value = -value;
		end else begin
			abs_value = value;
		end
	end

	// add 3 to every nibble that would reach 10 or more after the shift
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			if (bcd[4*i +: 4] >= 4'd5) begin
				bcd_adjusted[4*i +: 4] = bcd[4*i +: 4] + 4'd3;
			end else begin
				bcd_adjusted[4*i +: 4] = bcd[4*i +: 4];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= IDLE;
			conv_done <= 1'b0;
		end else begin
			conv_done <= 1'b0; // single cycle pulse
			case (state)
				IDLE: begin
					if (start) begin
						state <= SHIFT;
					end
				end
				SHIFT: begin
					if (bit_count == `MAG_WIDTH - 1) begin
						state <= FINISH;
					end
				end
				FINISH: begin
					state     <= IDLE;
					conv_done <= 1'b1;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			IDLE: begin
				if (start) begin
					shift_reg     <= abs_value[`MAG_WIDTH-1:0];
					bcd           <= '0;
					bit_count     <= '0;
					conv_negative <= value[`VALUE_WIDTH-1];
					// beyond four digits, or too big for the shifter at all
					conv_overflow <= abs_value[`VALUE_WIDTH-1] ||
						(abs_value > `MAX_MAGNITUDE);
				end
			end
			SHIFT: begin
				{bcd, shift_reg} <= {bcd_adjusted, shift_reg} << 1; // msb first
				bit_count        <= bit_count + 1'b1;
			end
			default: begin
			end
		endcase
	end

	// starts seen in any other state are dropped
	assign busy = (state != IDLE);

	// bcd holds still after the last shift, so these are good with conv_done
	assign raw_thousands = bcd[15:12];
	assign raw_hundreds  = bcd[11:8];
	assign raw_tens      = bcd[7:4];
	assign raw_units     = bcd[3:0];

endmodule

// ==== hdl/display_frame_register.sv ====
`timescale 1ns/1ps
`include "display_defines.svh"

module display_frame_register
	import display_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   conv_done,
	input  logic   conv_negative,
	input  logic   conv_overflow,
	input  digit_t raw_thousands,
	input  digit_t raw_hundreds,
	input  digit_t raw_tens,
	input  digit_t raw_units,
	output logic   show_negative,
	output digit_t digit_thousands,
	output digit_t digit_hundreds,
	output digit_t digit_tens,
	output digit_t digit_units
);

	logic blank_thousands;
	logic blank_hundreds;
	logic blank_tens;

	// a digit is blanked only if every digit to its left is blanked too
	assign blank_thousands = (raw_thousands == 4'd0);
	assign blank_hundreds  = blank_thousands && (raw_hundreds == 4'd0);
	assign blank_tens      = blank_hundreds && (raw_tens == 4'd0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			show_negative   <= 1'b0;
			digit_thousands <= `DIGIT_BLANK;
			digit_hundreds  <= `DIGIT_BLANK;
			digit_tens      <= `DIGIT_BLANK;
			digit_units     <= `DIGIT_BLANK;
		end else if (conv_done) begin
			if (conv_overflow) begin
				show_negative   <= 1'b0; // dashes carry no sign
				digit_thousands <= `DIGIT_DASH;
				digit_hundreds  <= `DIGIT_DASH;
				digit_tens      <= `DIGIT_DASH;
				digit_units     <= `DIGIT_DASH;
			end else begin
				show_negative   <= conv_negative;
				digit_thousands <= blank_thousands ? `DIGIT_BLANK : raw_thousands;
				digit_hundreds  <= blank_hundreds ? `DIGIT_BLANK : raw_hundreds;
				digit_tens      <= blank_tens ? `DIGIT_BLANK : raw_tens;
				digit_units     <= raw_units; // zero still shows one 0
			end
		end
	end

endmodule

// ==== hdl/quad_digit_segment_decoder.sv ====
`timescale 1ns/1ps
`include "display_defines.svh"

module quad_digit_segment_decoder
	import display_pkg::*;
(
	input  logic      show_negative,
	input  digit_t    digit_thousands,
	input  digit_t    digit_hundreds,
	input  digit_t    digit_tens,
	input  digit_t    digit_units,
	output logic      sign_seg,
	output segments_t seg_thousands,
	output segments_t seg_hundreds,
	output segments_t seg_tens,
	output segments_t seg_units
);

	// segments abcdefg, a lit segment is a 0
	function automatic segments_t decode_digit(input digit_t code);
		segments_t pattern;
		case (code)
			4'd0:        pattern = 7'b0000001;
			4'd1:        pattern = 7'b1001111;
			4'd2:        pattern = 7'b0010010;
			4'd3:        pattern = 7'b0000110;
			4'd4:        pattern = 7'b1001100;
			4'd5:        pattern = 7'b0100100;
			4'd6:        pattern = 7'b0100000;
			4'd7:        pattern = 7'b0001111;
			4'd8:        pattern = 7'b0000000;
			4'd9:        pattern = 7'b0000100;
			`DIGIT_DASH: pattern = 7'b1111110; // g only
			default:     pattern = 7'b1111111; // dark
		endcase
		return pattern;
	endfunction

	// minus lamp is driven active high
	assign sign_seg = show_negative;

	assign seg_thousands = decode_digit(digit_thousands);
	assign seg_hundreds  = decode_digit(digit_hundreds);
	assign seg_tens      = decode_digit(digit_tens);
	assign seg_units     = decode_digit(digit_units);

endmodule

// ==== hdl/signed_display_driver.sv ====
`timescale 1ns/1ps

module signed_display_driver
	import display_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      start,
	input  value_t    value,
	output logic      busy,
	output logic      sign_seg,
	output segments_t seg_thousands,
	output segments_t seg_hundreds,
	output segments_t seg_tens,
	output segments_t seg_units
);

	// converter result, valid with conv_done only
	logic   conv_done;
	logic   conv_negative;
	logic   conv_overflow;
	digit_t raw_thousands;
	digit_t raw_hundreds;
	digit_t raw_tens;
	digit_t raw_units;

	// held frame
	logic   show_negative;
	digit_t digit_thousands;
	digit_t digit_hundreds;
	digit_t digit_tens;
	digit_t digit_units;

	bin_to_bcd_converter u_bin_to_bcd_converter (
		.clk           (clk),
		.rst_n         (rst_n),
		.start         (start),
		.value         (value),
		.busy          (busy),
		.conv_done     (conv_done),
		.conv_negative (conv_negative),
		.conv_overflow (conv_overflow),
		.raw_thousands (raw_thousands),
		.raw_hundreds  (raw_hundreds),
		.raw_tens      (raw_tens),
		.raw_units     (raw_units)
	);

	display_frame_register u_display_frame_register (
		.clk             (clk),
		.rst_n           (rst_n),
		.conv_done       (conv_done),
		.conv_negative   (conv_negative),
		.conv_overflow   (conv_overflow),
		.raw_thousands   (raw_thousands),
		.raw_hundreds    (raw_hundreds),
		.raw_tens        (raw_tens),
		.raw_units       (raw_units),
		.show_negative   (show_negative),
		.digit_thousands (digit_thousands),
		.digit_hundreds  (digit_hundreds),
		.digit_tens      (digit_tens),
		.digit_units     (digit_units)
	);

	quad_digit_segment_decoder u_quad_digit_segment_decoder (
		.show_negative   (show_negative),
		.digit_thousands (digit_thousands),
		.digit_hundreds  (digit_hundreds),
		.digit_tens      (digit_tens),
		.digit_units     (digit_units),
		.sign_seg        (sign_seg),
		.seg_thousands   (seg_thousands),
		.seg_hundreds    (seg_hundreds),
		.seg_tens        (seg_tens),
		.seg_units       (seg_units)
	);

endmodule

// ==== tests/signed_display_driver_properties.sv ====
`timescale 1ns/1ps

module signed_display_driver_properties
	import display_pkg::*;
(
	input logic      clk,
	input logic      rst_n,
	input logic      start,
	input logic      busy,
	input logic      sign_seg,
	input segments_t seg_thousands,
	input segments_t seg_hundreds,
	input segments_t seg_tens,
	input segments_t seg_units
);

	logic [28:0] shown; // whole display, sign lamp first

	assign shown = {sign_seg, seg_thousands, seg_hundreds, seg_tens, seg_units};

	busy_rises: assert property (@(posedge clk) disable iff (!rst_n)
		start && !busy |=> busy)
		else $error("busy did not rise after a start taken while idle");

	// 14 shifts, one finish cycle, then the edge that sees busy low
	busy_falls: assert property (@(posedge clk) disable iff (!rst_n)
		start && !busy |-> ##16 $fell(busy))
		else $error("busy did not fall 16 cycles after an accepted start");

	display_holds: assert property (@(posedge clk) disable iff (!rst_n)
		busy |=> $stable(shown))
		else $error("display changed while a conversion was running");

endmodule

bind signed_display_driver signed_display_driver_properties u_signed_display_driver_properties (
	.clk           (clk),
	.rst_n         (rst_n),
	.start         (start),
	.busy          (busy),
	.sign_seg      (sign_seg),
	.seg_thousands (seg_thousands),
	.seg_hundreds  (seg_hundreds),
	.seg_tens      (seg_tens),
	.seg_units     (seg_units)
);

// ==== tests/signed_display_driver_tb.sv ====
`timescale 1ns/1ps
`include "display_defines.svh"

module signed_display_driver_tb
	import display_pkg::*;
();

	localparam int CLK_PERIOD   = 10;
	localparam int RESET_CYCLES = 16;
	localparam int CONV_CYCLES  = 16;    // start edge to first edge that samples busy low
	localparam int BUSY_TIMEOUT = 40;
	localparam int IDLE_TIMEOUT = 100;
	localparam int RUN_LIMIT    = 10000;
	localparam int RANDOM_COUNT = 200;

	localparam segments_t SEG_OFF  = 7'b1111111;
	localparam segments_t SEG_DASH = 7'b1111110; // middle bar g
	localparam segments_t DIGIT_SEGS [10] = '{
		7'b0000001, 7'b1001111, 7'b0010010, 7'b0000110, 7'b1001100,
		7'b0100100, 7'b0100000, 7'b0001111, 7'b0000000, 7'b0000100
	};

	logic      clk;
	logic      rst_n;
	logic      start;
	value_t    value;
	logic      busy;
	logic      sign_seg;
	segments_t seg_thousands;
	segments_t seg_hundreds;
	segments_t seg_tens;
	segments_t seg_units;

	int     errors      = 0;
	int     checks      = 0;
	bit     run_over    = 1'b0;
	bit     exp_pending = 1'b0; // a result is awaited by the compare process
	value_t exp_value;
	string  exp_name;

	signed_display_driver u_signed_display_driver (
		.clk           (clk),
		.rst_n         (rst_n),
		.start         (start),
		.value         (value),
		.busy          (busy),
		.sign_seg      (sign_seg),
		.seg_thousands (seg_thousands),
		.seg_hundreds  (seg_hundreds),
		.seg_tens      (seg_tens),
		.seg_units     (seg_units)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			$display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
			errors++;
		end
	endtask

	// sign lamp followed by the four patterns, thousands first
	function automatic logic [28:0] expected_display(input value_t v);
		int        magnitude;
		int        digits [4];
		segments_t segs [4];
		bit        leading;
		magnitude = (v < 0) ? -int'(v) : int'(v);
		if (magnitude > `MAX_MAGNITUDE) begin
			return {1'b0, SEG_DASH, SEG_DASH, SEG_DASH, SEG_DASH}; // no sign on dashes
		end
		digits[0] = magnitude / 1000;
		digits[1] = (magnitude / 100) % 10;
		digits[2] = (magnitude / 10) % 10;
		digits[3] = magnitude % 10;
		leading = 1'b1;
		for (int i = 0; i < 4; i++) begin
			if (leading && digits[i] == 0 && i < 3) begin
				segs[i] = SEG_OFF;
			end else begin
				leading = 1'b0;
				segs[i] = DIGIT_SEGS[digits[i]];
			end
		end
		return {(v < 0), segs[0], segs[1], segs[2], segs[3]};
	endfunction

	task automatic wait_until_idle(input string what);
		int waited;
		waited = 0;
		while ((exp_pending || busy) && waited < IDLE_TIMEOUT) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (exp_pending || busy) begin
			$display("timeout: previous conversion never finished before %s", what);
			errors++;
			run_over = 1'b1;
		end
	endtask

	// the second start lands while busy is high and must be dropped
	task automatic apply_value(input string name, input value_t v, input bit second_start,
			input value_t second_value);
		wait_until_idle(name);
		if (!run_over) begin
			start = 1'b1;
			value = v;
			@(posedge clk);
			#1;
			exp_value   = v;
			exp_name    = name;
			exp_pending = 1'b1;
			start       = second_start;
			value       = second_value;
			@(posedge clk);
			#1;
			start = 1'b0;
		end
	endtask

	initial begin : stimulus
		value_t rand_value;
		start = 1'b0;
		value = '0;
		rst_n = 1'b0;
		void'($urandom(32'hbfe6));
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		check_value("reset busy", 0, busy);
		check_value("reset sign_seg", 0, sign_seg);
		check_value("reset seg_thousands", SEG_OFF, seg_thousands);
		check_value("reset seg_hundreds", SEG_OFF, seg_hundreds);
		check_value("reset seg_tens", SEG_OFF, seg_tens);
		check_value("reset seg_units", SEG_OFF, seg_units);
		rst_n = 1'b1;
		apply_value("zero", 0, 1'b0, 0);
		apply_value("seven", 7, 1'b0, 0);
		apply_value("four hundred five", 405, 1'b0, 0);
		apply_value("max positive", 9999, 1'b0, 0);
		apply_value("minus 9999", -9999, 1'b0, 0);
		apply_value("minus 12", -12, 1'b0, 0);
		apply_value("plus 10000", 10000, 1'b0, 0);
		apply_value("minus 10000", -10000, 1'b0, 0);
		apply_value("largest value", 16383, 1'b0, 0);
		apply_value("most negative", -16384, 1'b0, 0);
		apply_value("start while busy", 321, 1'b1, -77);
		for (int i = 0; i < RANDOM_COUNT; i++) begin
			rand_value = value_t'($urandom);
			apply_value($sformatf("random %0d", i), rand_value, 1'b0, 0);
		end
		wait_until_idle("end of run"); // last result still being compared
		run_over = 1'b1;
	end

	// samples on the falling edge, away from the drive points
	initial begin : compare_results
		int          idle;
		int          cycles;
		logic [28:0] expected;
		while (!run_over) begin
			idle = 0;
			while (!exp_pending && !run_over && idle < IDLE_TIMEOUT) begin
				@(negedge clk);
				idle++;
			end
			if (idle >= IDLE_TIMEOUT) begin
				$display("no conversion was started within %0d cycles", IDLE_TIMEOUT);
				errors++;
				run_over = 1'b1;
			end else if (exp_pending) begin
				cycles = 1; // busy seen here is what the next edge samples
				while (busy && cycles < BUSY_TIMEOUT) begin
					@(negedge clk);
					cycles++;
				end
				if (busy) begin
					$display("timeout: busy still high %0d cycles after %s started",
						BUSY_TIMEOUT, exp_name);
					errors++;
					run_over = 1'b1;
				end else begin
					check_value({exp_name, " busy cycles"}, CONV_CYCLES, cycles);
					@(negedge clk); // frame register loads one edge later
					expected = expected_display(exp_value);
					check_value({exp_name, " sign_seg"}, expected[28], sign_seg);
					check_value({exp_name, " seg_thousands"}, expected[27:21], seg_thousands);
					check_value({exp_name, " seg_hundreds"}, expected[20:14], seg_hundreds);
					check_value({exp_name, " seg_tens"}, expected[13:7], seg_tens);
					check_value({exp_name, " seg_units"}, expected[6:0], seg_units);
					exp_pending = 1'b0;
				end
			end
		end
	end

	initial begin : end_of_run
		int waited;
		waited = 0;
		while (!run_over && waited < RUN_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		if (!run_over) begin
			$display("simulation stopped after %0d cycles without finishing", RUN_LIMIT);
			errors++;
		end
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+include
hdl/display_pkg.sv
hdl/bin_to_bcd_converter.sv
hdl/display_frame_register.sv
hdl/quad_digit_segment_decoder.sv
hdl/signed_display_driver.sv
tests/signed_display_driver_properties.sv
tests/signed_display_driver_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := signed_display_driver_tb
FILELIST   := verilog.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_TEXT  := Test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
